/* io_map_pkg.sv */
package io_map_pkg;

    // ------------------------------------------------------------------------
    // Register addresses on the processor data bus
    // ------------------------------------------------------------------------

    // Status, bit 0 tx ready and bit 1 rx valid
    localparam logic [31:0] io_addr_status  = 32'h8000_0000;

    // Received byte, consumed by a load
    localparam logic [31:0] io_addr_rx_data = 32'h8000_0004;

    // Transmit byte, a store starts a frame
    localparam logic [31:0] io_addr_tx_data = 32'h8000_0008;

    // ------------------------------------------------------------------------
    // Decoded register select
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        reg_status  = 2'd0,
        reg_rx_data = 2'd1,
        reg_tx_data = 2'd2,
        reg_none    = 2'd3
    } io_reg_sel_e;

    // ------------------------------------------------------------------------
    // Bus request from the processor, one access per cycle
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] store_data;
        // Any set enable marks a store
        logic [3:0]  byte_en;
        logic        load;
    } io_bus_req_t;

endpackage

/* uart_pkg.sv */
package uart_pkg;

    // ------------------------------------------------------------------------
    // Serial line format, 8N1
    // ------------------------------------------------------------------------

    localparam int   uart_data_bits = 8;
    localparam logic uart_line_idle = 1'b1;
    localparam logic uart_start_bit = 1'b0;
    localparam logic uart_stop_bit  = 1'b1;

    typedef logic [uart_data_bits-1:0] uart_byte_t;

    // Byte with its valid, used in both directions
    typedef struct packed {
        uart_byte_t data;
        logic       valid;
    } uart_chan_t;

    // ------------------------------------------------------------------------
    // Frame state machines
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        tx_idle, tx_start, tx_data, tx_stop
    } uart_tx_state_e;

    typedef enum logic [1:0] {
        rx_idle, rx_start, rx_data, rx_stop
    } uart_rx_state_e;

endpackage

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 8
)
(
    input  logic       Clock,
    input  logic       arst_n,
    input  uart_chan_t tx_req,
    output logic       tx_ready,
    output logic       serial_out
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
    localparam int idx_w = $clog2(uart_data_bits);
    localparam logic [idx_w-1:0] idx_last = idx_w'(uart_data_bits - 1);

    uart_tx_state_e   state;
    logic [cnt_w-1:0] bit_cnt;
    logic [idx_w-1:0] bit_idx;
    uart_byte_t       shift_q;
    logic             bit_end;
    logic             accept;

    // Ready only between frames
    assign tx_ready = (state == tx_idle);
    assign accept   = tx_ready && tx_req.valid;
    assign bit_end  = (bit_cnt == cnt_last);

    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= tx_idle;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            serial_out <= uart_line_idle;
        end
        else
        begin
            // Bit time counter wraps at each bit boundary
            if (state == tx_idle || bit_end)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;

            case (state)
                tx_idle:
                begin
                    if (accept)
                    begin
                        state      <= tx_start;
                        serial_out <= uart_start_bit;
                    end
                end
                tx_start:
                begin
                    if (bit_end)
                    begin
                        state      <= tx_data;
                        bit_idx    <= '0;
                        serial_out <= shift_q[0];
                    end
                end
                tx_data:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == idx_last)
                        begin
                            state      <= tx_stop;
                            serial_out <= uart_stop_bit;
                        end
                        else
                        begin
                            bit_idx    <= bit_idx + 1'b1;
                            serial_out <= shift_q[0];
                        end
                    end
                end
                default:
                begin
                    // Stop bit held a full bit time, then ready again
                    if (bit_end)
                        state <= tx_idle;
                end
            endcase
        end
    end

    // Data shifts out LSB first
    always_ff @(posedge Clock)
    begin
        if (accept)
            shift_q <= tx_req.data;
        else if (bit_end && (state == tx_start || state == tx_data))
            shift_q <= shift_q >> 1;
    end

endmodule

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 8
)
(
    input  logic       Clock,
    input  logic       arst_n,
    input  logic       serial_in,
    output uart_chan_t rx_done
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] cnt_half =
        cnt_w'((clks_per_bit > 1) ? (clks_per_bit / 2 - 1) : 0);
    localparam int idx_w = $clog2(uart_data_bits);
    localparam logic [idx_w-1:0] idx_last = idx_w'(uart_data_bits - 1);

    logic [1:0]       sync_q;
    logic             rx_line;
    uart_rx_state_e   state;
    logic [cnt_w-1:0] bit_cnt;
    logic [idx_w-1:0] bit_idx;
    uart_byte_t       shift_q;
    logic             done_q;
    logic             sample;

    // ------------------------------------------------------------------------
    // Input synchronizer
    // ------------------------------------------------------------------------

    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
            sync_q <= {uart_line_idle, uart_line_idle};
        else
            sync_q <= {sync_q[0], serial_in};
    end

    assign rx_line = sync_q[1];

    // Mid-bit sample point for data and stop bits
    assign sample = (bit_cnt == cnt_last);

    // ------------------------------------------------------------------------
    // Frame state machine
    // ------------------------------------------------------------------------

    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= rx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                rx_idle:
                begin
                    bit_cnt <= '0;
                    if (rx_line == uart_start_bit)
                        state <= rx_start;
                end
                rx_start:
                begin
                    if (bit_cnt == cnt_half)
                    begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch shorter than half a bit is a false start
                        state   <= (rx_line == uart_start_bit) ? rx_data : rx_idle;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                rx_data:
                begin
                    if (sample)
                    begin
                        bit_cnt <= '0;
                        if (bit_idx == idx_last)
                            state <= rx_stop;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                default:
                begin
                    // Back to idle at mid-stop so the next start edge is seen
                    if (sample)
                    begin
                        state  <= rx_idle;
                        done_q <= (rx_line == uart_stop_bit);
                    end
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge Clock)
    begin
        if (state == rx_data && sample)
            shift_q <= {rx_line, shift_q[uart_data_bits-1:1]};
    end

    assign rx_done.data  = shift_q;
    assign rx_done.valid = done_q;

endmodule

/* uart.sv */
`timescale 1ns/1ps

module uart
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 8
)
(
    input  logic       Clock,
    input  logic       arst_n,
    input  uart_chan_t tx_req,
    output logic       tx_ready,
    output uart_chan_t rx_resp,
    input  logic       rx_ack,
    input  logic       serial_in,
    output logic       serial_out
);

    uart_chan_t rx_done;
    uart_byte_t rx_hold_data;
    logic       rx_hold_valid;

    uart_tx #(.clks_per_bit(clks_per_bit)) tx0 (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .tx_req     (tx_req),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx #(.clks_per_bit(clks_per_bit)) rx0 (
        .Clock     (Clock),
        .arst_n    (arst_n),
        .serial_in (serial_in),
        .rx_done   (rx_done)
    );

    // Holding register, a new byte wins over a same-cycle ack
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
            rx_hold_valid <= 1'b0;
        else if (rx_done.valid)
            rx_hold_valid <= 1'b1;
        else if (rx_ack)
            rx_hold_valid <= 1'b0;
    end

    always_ff @(posedge Clock)
    begin
        if (rx_done.valid)
            rx_hold_data <= rx_done.data;
    end

    assign rx_resp.data  = rx_hold_data;
    assign rx_resp.valid = rx_hold_valid;

endmodule

/* io_interface.sv */
`timescale 1ns/1ps

module io_interface
    import io_map_pkg::*;
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 8
)
(
    input  logic        Clock,
    input  logic        arst_n,
    input  io_bus_req_t bus_req,
    output logic [31:0] load_data,
    input  logic        serial_in,
    output logic        serial_out
);

    io_reg_sel_e reg_sel;
    logic        is_store;
    uart_byte_t  tx_byte;
    uart_chan_t  tx_req;
    logic        tx_ready;
    uart_chan_t  rx_resp;
    logic        rx_ack;
    logic [31:0] load_next;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------

    always_comb
    begin
        case (bus_req.addr)
            io_addr_status:  reg_sel = reg_status;
            io_addr_rx_data: reg_sel = reg_rx_data;
            io_addr_tx_data: reg_sel = reg_tx_data;
            default:         reg_sel = reg_none;
        endcase
    end

    assign is_store = |bus_req.byte_en;

    // ------------------------------------------------------------------------
    // Transmit side
    // ------------------------------------------------------------------------

    // Byte lane of the lowest set enable
    always_comb
    begin
        priority casez (bus_req.byte_en)
            4'b???1: tx_byte = bus_req.store_data[7:0];
            4'b??10: tx_byte = bus_req.store_data[15:8];
            4'b?100: tx_byte = bus_req.store_data[23:16];
            4'b1000: tx_byte = bus_req.store_data[31:24];
            default: tx_byte = bus_req.store_data[7:0];
        endcase
    end

    // One-cycle request, dropped by the UART when busy
    assign tx_req.data  = tx_byte;
    assign tx_req.valid = is_store && (reg_sel == reg_tx_data);

    // ------------------------------------------------------------------------
    // Load path
    // ------------------------------------------------------------------------

    // Reading rx data consumes the byte
    assign rx_ack = bus_req.load && (reg_sel == reg_rx_data);

    always_comb
    begin
        case (reg_sel)
            reg_status:  load_next = {30'b0, rx_resp.valid, tx_ready};
            reg_rx_data: load_next = {{(32 - uart_data_bits){1'b0}}, rx_resp.data};
            default:     load_next = '0;
        endcase
    end

    // Load value appears the cycle after the strobe
    always_ff @(posedge Clock or negedge arst_n)
    begin
        if (!arst_n)
            load_data <= '0;
        else if (bus_req.load)
            load_data <= load_next;
    end

    uart #(.clks_per_bit(clks_per_bit)) uart0 (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .tx_req     (tx_req),
        .tx_ready   (tx_ready),
        .rx_resp    (rx_resp),
        .rx_ack     (rx_ack),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

endmodule

/* io_tb_assert.sv */
`timescale 1ns/1ps

module io_tb_assert
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 8
)
(
    input logic       Clock,
    input logic       arst_n,
    input uart_chan_t tx_req,
    input logic       tx_ready,
    input uart_chan_t rx_resp,
    input logic       rx_ack,
    input logic       serial_out
);

    localparam int frame_clks = 10 * clks_per_bit;

    // Idle transmitter keeps the line high
    idle_line_high: assert property (@(posedge Clock) disable iff (!arst_n)
        tx_ready |-> serial_out)
        else $error("serial_out low while the transmitter is idle");

    // Accepted byte keeps the transmitter busy for all ten bits
    busy_for_frame: assert property (@(posedge Clock) disable iff (!arst_n)
        (tx_req.valid && tx_ready) |=> !tx_ready [*frame_clks])
        else $error("tx_ready rose before the frame ended");

    // Only an ack clears a held byte
    rx_valid_held: assert property (@(posedge Clock) disable iff (!arst_n)
        $fell(rx_resp.valid) |-> $past(rx_ack))
        else $error("rx valid fell without rx_ack");

endmodule

bind uart io_tb_assert #(.clks_per_bit(clks_per_bit)) chk0 (
    .Clock      (Clock),
    .arst_n     (arst_n),
    .tx_req     (tx_req),
    .tx_ready   (tx_ready),
    .rx_resp    (rx_resp),
    .rx_ack     (rx_ack),
    .serial_out (serial_out)
);

/* io_tb.sv */
`timescale 1ns/1ps

module io_tb
    import io_map_pkg::*;
    import uart_pkg::*;
();

    localparam int clks_per_bit = 8;
    localparam int clk_period = 8;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic        Clock;
    logic        arst_n;
    io_bus_req_t bus_req;
    logic [31:0] load_data;
    logic        serial_in;
    logic        serial_out;

    // Trace operations, one entry per line of the file
    logic [7:0]  op_code[$];
    logic [31:0] op_a[$];
    logic [31:0] op_b[$];
    logic [31:0] op_c[$];
    uart_byte_t  line_bytes[$];
    logic [31:0] lfsr;

    io_interface #(.clks_per_bit(clks_per_bit)) dut0 (
        .Clock      (Clock),
        .arst_n     (arst_n),
        .bus_req    (bus_req),
        .load_data  (load_data),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    initial
    begin
        Clock = 1'b0;
        forever
            #(clk_period / 2) Clock = ~Clock;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                                name, actual, expected));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Ends 1 ns after a rising edge, where inputs change
    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge Clock);
            #1;
        end
    endtask

    task automatic bus_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        bus_req.addr       = addr;
        bus_req.store_data = data;
        bus_req.byte_en    = be;
        wait_cycles(1);
        bus_req.byte_en    = 4'b0;
    endtask

    task automatic bus_load(input logic [31:0] addr, output logic [31:0] data);
        bus_req.addr = addr;
        bus_req.load = 1'b1;
        wait_cycles(1);
        bus_req.load = 1'b0;
        data = load_data;
    endtask

    // 8N1 frame on serial_in, sometimes shifted by half a bit
    task automatic send_byte(input uart_byte_t b);
        int skew;
        draw_bits(1, skew);
        if (skew != 0)
            wait_cycles(clks_per_bit / 2);
        serial_in = 1'b0;
        wait_cycles(clks_per_bit);
        for (int i = 0; i < 8; i++)
        begin
            serial_in = b[i];
            wait_cycles(clks_per_bit);
        end
        serial_in = 1'b1;
        wait_cycles(clks_per_bit);
    endtask

    // ------------------------------------------------------------------------
    // Trace file
    // ------------------------------------------------------------------------

    task automatic read_trace();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("io_trace.txt", "r");
        if (fd == 0)
            abort_run("could not open io_trace.txt");
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#")
                begin
                    a = '0;
                    b = '0;
                    c = '0;
                    n = $sscanf(line, "%c %h %h %h", op, a, b, c);
                    op_code.push_back(op);
                    op_a.push_back(a);
                    op_b.push_back(b);
                    op_c.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_op(input int i);
        logic [31:0] value;
        case (op_code[i])
            "W": bus_store(op_a[i], op_b[i], op_c[i][3:0]);
            "R":
            begin
                bus_load(op_a[i], value);
                check_value($sformatf("load_data @%08h", op_a[i]), value, op_b[i]);
            end
            "S": send_byte(op_a[i][7:0]);
            "E":
            begin
                if (line_bytes.size() == 0)
                    abort_run("expected a byte on serial_out but none was received");
                else
                    check_value("serial_out byte", line_bytes.pop_front(), op_a[i]);
            end
            "P":
            begin
                do
                    bus_load(io_addr_status, value);
                while (value[op_a[i][4:0]] !== 1'b1);
            end
            "N":
            begin
                if (line_bytes.size() != 0)
                    abort_run("serial_out carried a byte that was not expected");
            end
            default: abort_run("unknown operation in io_trace.txt");
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Serial line monitor, samples at mid-bit
    // ------------------------------------------------------------------------

    initial
    begin : line_monitor
        uart_byte_t rx_byte;
        wait (arst_n === 1'b1);
        forever
        begin
            @(negedge serial_out);
            repeat (clks_per_bit / 2) @(negedge Clock);
            if (serial_out !== 1'b0)
                abort_run("start bit on serial_out ended before mid-bit");
            for (int i = 0; i < 8; i++)
            begin
                repeat (clks_per_bit) @(negedge Clock);
                rx_byte[i] = serial_out;
            end
            repeat (clks_per_bit) @(negedge Clock);
            if (serial_out !== 1'b1)
                abort_run("stop bit on serial_out was low");
            line_bytes.push_back(rx_byte);
        end
    end

    initial
    begin : main_flow
        int gap;
        arst_n    = 1'b0;
        bus_req   = '0;
        serial_in = 1'b1;
        lfsr      = 32'd81125;
        read_trace();
        fork
            begin : watchdog
                #(op_code.size() * 12 * clks_per_bit * clk_period + 5000);
                abort_run("timeout, the trace did not finish in time");
            end
        join_none
        wait_cycles(16);
        arst_n = 1'b1;
        check_value("serial_out", serial_out, 32'h1);
        check_value("load_data", load_data, 32'h0);
        for (int i = 0; i < op_code.size(); i++)
        begin
            run_op(i);
            draw_bits(3, gap);
            wait_cycles(gap);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* io_trace.txt */
# op  a         b         c   W addr data byte_en | R addr expected | S byte | E byte
# P status_bit (poll until set) | N (no byte left on serial_out)
R 80000000 00000001
W 80000008 000000A5 1
R 80000000 00000000
W 80000008 00000077 1
P 0
E A5
N
W 80000008 12345678 4
P 0
E 34
N
S 3C
P 1
R 80000004 0000003C
R 80000000 00000001
S 11
S 22
R 80000000 00000003
R 80000004 00000022
R 80000000 00000001
R 80000010 00000000
R 00000000 00000000
W 80000008 0000005A 1
S C3
P 0
E 5A
P 1
R 80000004 000000C3
R 80000000 00000001
N

/* list.f */
io_map_pkg.sv
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart.sv
io_interface.sv
io_tb_assert.sv
io_tb.sv
